//--- bench/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// one decode test: the stimulus first, then the rules the expected outputs come from
typedef struct {
    string                name;
    logic [31:0]          inst;
    logic [31:0]          pc;
    logic                 es_we;
    logic [4:0]           es_addr;
    logic [31:0]          es_data;
    logic                 ms_we;
    logic [4:0]           ms_addr;
    logic [31:0]          ms_data;
    int                   stall;     // cycles es_res_from_mem is held high
    int                   hold;      // cycles es_allowin is held low
    logic                 flush;     // flush instead of leaving to execute
    decode_pkg::alu_op_e  alu;
    logic                 src1_pc;   // alu_src1 is the pc, else rj
    logic                 src2_imm;  // alu_src2 is imm, else the second register
    logic [31:0]          imm;
    logic                 r2_rd;     // second register is rd, else rk
    logic                 we;
    logic                 ine;
    decode_pkg::br_kind_e kind;
    logic [31:0]          offs;
    logic                 store;     // st.w writes memory
    logic                 load;      // ld.w result comes from memory
} vec_t;

vec_t vectors [] = '{
    '{"add_w", {17'h00020, 5'd3, 5'd2, 5'd5}, 32'h1c00_0000, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_add, 0, 0, 0, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"sub_w_es_fwd", {17'h00022, 5'd3, 5'd2, 5'd6}, 32'h1c00_0004,
      1, 2, 32'h1111_0000, 1, 2, 32'h2222_0000, 0, 0, 0,
      decode_pkg::alu_sub, 0, 0, 0, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"or_ms_fwd", {17'h0002a, 5'd3, 5'd4, 5'd7}, 32'h1c00_0008,
      0, 3, 32'h3333_0000, 1, 3, 32'h4444_0000, 0, 0, 0,
      decode_pkg::alu_or, 0, 0, 0, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"xor_r0", {17'h0002b, 5'd0, 5'd0, 5'd8}, 32'h1c00_000c,
      1, 0, 32'hdead_beef, 1, 0, 32'hbeef_dead, 0, 0, 0,
      decode_pkg::alu_xor, 0, 0, 0, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"slli_w", {17'h00081, 5'd7, 5'd4, 5'd6}, 32'h1c00_0010, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_sll, 0, 1, 32'h27, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"addi_w", {10'h00a, 12'hffc, 5'd8, 5'd9}, 32'h1c00_0014, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_add, 0, 1, 32'hffff_fffc, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"andi", {10'h00d, 12'h8f0, 5'd8, 5'd10}, 32'h1c00_0018, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_and, 0, 1, 32'h8f0, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"lu12i_w", {7'h0a, 20'h12345, 5'd11}, 32'h1c00_001c, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_lui, 0, 1, 32'h1234_5000, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"pcaddu12i", {7'h0e, 20'h00001, 5'd12}, 32'h1c00_0100, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_add, 1, 1, 32'h1000, 0, 1, 0, decode_pkg::br_none, 0, 0, 0},
    '{"ld_w_use", {10'h0a2, 12'h008, 5'd14, 5'd13}, 32'h1c00_0104,
      1, 14, 32'h4000_0000, 0, 0, 0, 3, 0, 0,
      decode_pkg::alu_add, 0, 1, 32'h8, 0, 1, 0, decode_pkg::br_none, 0, 0, 1},
    '{"st_w_hold", {10'h0a6, 12'h010, 5'd15, 5'd16}, 32'h1c00_0108, 0, 0, 0, 0, 0, 0, 0, 2, 0,
      decode_pkg::alu_add, 0, 1, 32'h10, 1, 0, 0, decode_pkg::br_none, 0, 1, 0},
    '{"beq_taken", {6'h16, 16'h0004, 5'd17, 5'd17}, 32'h1c00_0200, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_sub, 0, 0, 0, 1, 0, 0, decode_pkg::br_beq, 32'h10, 0, 0},
    '{"bne", {6'h17, 16'hfffe, 5'd17, 5'd17}, 32'h1c00_0204, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_sub, 0, 0, 0, 1, 0, 0, decode_pkg::br_bne, 32'hffff_fff8, 0, 0},
    '{"blt", {6'h18, 16'h0020, 5'd18, 5'd19}, 32'h1c00_0208, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_slt, 0, 0, 0, 1, 0, 0, decode_pkg::br_blt, 32'h80, 0, 0},
    '{"bge", {6'h19, 16'h0020, 5'd18, 5'd19}, 32'h1c00_020c, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_slt, 0, 0, 0, 1, 0, 0, decode_pkg::br_bge, 32'h80, 0, 0},
    '{"bltu", {6'h1a, 16'h0020, 5'd22, 5'd23}, 32'h1c00_0210, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_sltu, 0, 0, 0, 1, 0, 0, decode_pkg::br_bltu, 32'h80, 0, 0},
    '{"bgeu", {6'h1b, 16'h0020, 5'd22, 5'd23}, 32'h1c00_0214, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_sltu, 0, 0, 0, 1, 0, 0, decode_pkg::br_bgeu, 32'h80, 0, 0},
    '{"b", {6'h14, 16'hff00, 10'h3ff}, 32'h1c00_0300, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_add, 0, 0, 0, 0, 0, 0, decode_pkg::br_b, 32'hffff_fc00, 0, 0},
    '{"bl", {6'h15, 16'h0010, 10'h000}, 32'h1c00_0304, 0, 0, 0, 0, 0, 0, 0, 0, 0,
      decode_pkg::alu_add, 1, 1, 32'h4, 0, 1, 0, decode_pkg::br_bl, 32'h40, 0, 0},
    '{"jirl_hold", {6'h13, 16'h0008, 5'd21, 5'd20}, 32'h1c00_0308, 0, 0, 0, 0, 0, 0, 0, 1, 0,
      decode_pkg::alu_add, 1, 1, 32'h4, 0, 1, 0, decode_pkg::br_jirl, 32'h20, 0, 0},
    '{"ine_flush", 32'hffff_ffff, 32'h1c00_030c, 0, 0, 0, 0, 0, 0, 0, 0, 1,
      decode_pkg::alu_add, 0, 0, 0, 0, 0, 1, decode_pkg::br_none, 0, 0, 0}
};

`endif

//--- bench/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
    logic        clk = 1'b0;
    logic        resetn, flush, fs_valid, es_allowin, es_res_from_mem;
    logic [31:0] fs_pc, fs_inst;
    logic        es_rf_we, ms_rf_we, ws_rf_we;
    logic [4:0]  es_rf_waddr, ms_rf_waddr, ws_rf_waddr;
    logic [31:0] es_rf_wdata, ms_rf_wdata, ws_rf_wdata;
    logic        allowin, br_taken, es_valid, mem_we, res_from_mem, rf_we, ine;
    logic [31:0] br_target, es_pc, alu_src1, alu_src2, store_data;
    logic [4:0]  rf_waddr;
    decode_pkg::alu_op_e alu_op;

    `include "decode_vectors.svh"

    logic [31:0] reg_model [32];  // contents after preload
    int          cycles = 0;
    int          limit;
    int          test_errs, n_pass, n_fail;
    string       cur_name;

    decode_stage i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // es, then ms, then the preloaded register; r0 never forwards
    function automatic logic [31:0] operand(vec_t v, logic [4:0] a);
        if (a == 5'd0) return 32'd0;
        if (v.es_we && v.es_addr == a) return v.es_data;
        if (v.ms_we && v.ms_addr == a) return v.ms_data;
        return reg_model[a];
    endfunction

    function automatic logic branch_cond(decode_pkg::br_kind_e k, logic [31:0] a, logic [31:0] b);
        case (k)
            decode_pkg::br_beq:  return a == b;
            decode_pkg::br_bne:  return a != b;
            decode_pkg::br_blt:  return $signed(a) < $signed(b);
            decode_pkg::br_bge:  return $signed(a) >= $signed(b);
            decode_pkg::br_bltu: return a < b;
            decode_pkg::br_bgeu: return a >= b;
            decode_pkg::br_b, decode_pkg::br_bl, decode_pkg::br_jirl: return 1'b1;
            default:             return 1'b0;
        endcase
    endfunction

    task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic fail_plain(string msg);
        $display("%s: %s", cur_name, msg);
        test_errs++;
    endtask

    task automatic finish_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s: pass", cur_name);
        end else begin
            n_fail++;
            $display("test %s: fail (%0d errors)", cur_name, test_errs);
        end
    endtask

    task automatic run_vector(vec_t v);
        logic [31:0] rj, r2, src1;
        logic [4:0]  r2a;
        logic        taken;
        int          hold;
        @(negedge clk);
        cur_name        = v.name;
        test_errs       = 0;
        es_rf_we        = v.es_we;
        es_rf_waddr     = v.es_addr;
        es_rf_wdata     = v.es_data;
        ms_rf_we        = v.ms_we;
        ms_rf_waddr     = v.ms_addr;
        ms_rf_wdata     = v.ms_data;
        es_res_from_mem = v.stall > 0;
        es_allowin      = 1'b0;
        fs_valid        = 1'b1;
        fs_pc           = v.pc;
        fs_inst         = v.inst;
        @(posedge clk);
        @(negedge clk);
        fs_valid = 1'b0;
        for (int k = 0; k < v.stall; k++) begin
            #1;
            if (es_valid || allowin) fail_plain("stage issued or accepted during load-use stall");
            @(posedge clk);
            @(negedge clk);
        end
        es_res_from_mem = 1'b0;
        rj    = operand(v, v.inst[9:5]);
        r2a   = v.r2_rd ? v.inst[4:0] : v.inst[14:10];
        r2    = operand(v, r2a);
        src1  = v.src1_pc ? v.pc : rj;
        taken = !v.flush && branch_cond(v.kind, rj, r2);
        hold  = v.hold + ($urandom % 2);  // random extra back-pressure cycle
        repeat (hold) begin
            @(posedge clk);
            #1;
            if (!es_valid || allowin) fail_plain("stage did not hold under back-pressure");
            compare("held alu_src1", src1, alu_src1);
            compare("held es_pc", v.pc, es_pc);
            @(negedge clk);
        end
        es_allowin = !v.flush;
        flush      = v.flush;
        #1;
        if (!es_valid) fail_plain("es_valid low with a held instruction");
        compare("es_pc", v.pc, es_pc);
        compare("alu_op", v.alu, alu_op);
        compare("alu_src1", src1, alu_src1);
        compare("alu_src2", v.src2_imm ? v.imm : r2, alu_src2);
        compare("store_data", r2, store_data);
        compare("mem_we", v.store, mem_we);
        compare("res_from_mem", v.load, res_from_mem);
        compare("rf_we", v.we, rf_we);
        compare("ine", v.ine, ine);
        if (v.we) compare("rf_waddr", (v.kind == decode_pkg::br_bl) ? 5'd1 : v.inst[4:0], rf_waddr);
        compare("br_taken", taken, br_taken);
        if (v.kind != decode_pkg::br_none) begin
            compare("br_target", ((v.kind == decode_pkg::br_jirl) ? rj : v.pc) + v.offs,
                    br_target);
        end
        @(posedge clk);
        @(negedge clk);
        flush      = 1'b0;
        es_allowin = 1'b0;
        #1;
        if (es_valid || !allowin) fail_plain("stage did not empty after leaving or flush");
        finish_test();
    endtask

    initial begin
        void'($urandom(32'hedc9472c));
        limit           = 20 + 12 * vectors.size();
        n_pass          = 0;
        n_fail          = 0;
        resetn          = 1'b0;
        flush           = 1'b0;
        fs_valid        = 1'b0;
        fs_pc           = '0;
        fs_inst         = '0;
        es_allowin      = 1'b0;
        es_res_from_mem = 1'b0;
        es_rf_we        = 1'b0;
        es_rf_waddr     = '0;
        es_rf_wdata     = '0;
        ms_rf_we        = 1'b0;
        ms_rf_waddr     = '0;
        ms_rf_wdata     = '0;
        ws_rf_we        = 1'b0;
        ws_rf_waddr     = '0;
        ws_rf_wdata     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn    = 1'b1;
        cur_name  = "reset";
        test_errs = 0;
        #1;
        if (!allowin || es_valid || br_taken || rf_we) fail_plain("outputs not idle after reset");
        finish_test();
        reg_model[0] = 32'd0;
        for (int r = 1; r < 32; r++) begin  // preload through writeback
            @(negedge clk);
            ws_rf_we     = 1'b1;
            ws_rf_waddr  = r[4:0];
            ws_rf_wdata  = $urandom;
            reg_model[r] = ws_rf_wdata;
        end
        @(negedge clk);
        ws_rf_we = 1'b0;
        foreach (vectors[i]) run_vector(vectors[i]);
        $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- design/decode_ifc.sv
`timescale 1ns/1ps

interface read_req_if;
    logic [decode_pkg::reg_addr_w-1:0] raddr1;
    logic [decode_pkg::reg_addr_w-1:0] raddr2;
    logic                              need_r1;
    logic                              need_r2;

    modport src (output raddr1, raddr2, need_r1, need_r2);
    modport dst (input raddr1, raddr2, need_r1, need_r2);
endinterface

interface dec_ctrl_if;
    decode_pkg::alu_op_e               alu_op;
    logic                              src1_is_pc;
    logic                              src2_is_imm;
    logic [decode_pkg::xlen-1:0]       imm;
    decode_pkg::br_kind_e              br_kind;
    logic [decode_pkg::xlen-1:0]       br_offs;
    logic                              mem_we;
    logic                              res_from_mem;  // ld.w
    logic                              gr_we;
    logic [decode_pkg::reg_addr_w-1:0] dest;
    logic                              ine;           // unknown encoding

    modport src (
        output alu_op, src1_is_pc, src2_is_imm, imm, br_kind, br_offs,
               mem_we, res_from_mem, gr_we, dest, ine
    );
    modport dst (
        input  alu_op, src1_is_pc, src2_is_imm, imm, br_kind, br_offs,
               mem_we, res_from_mem, gr_we, dest, ine
    );
endinterface

//--- design/decode_pkg.sv
package decode_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam logic [reg_addr_w-1:0] link_reg = 5'd1; // bl return address

    // 3R and shift-immediate forms, compared against inst[31:15]
    localparam logic [16:0] op6_add_w  = 17'h00020;
    localparam logic [16:0] op6_sub_w  = 17'h00022;
    localparam logic [16:0] op6_slt    = 17'h00024;
    localparam logic [16:0] op6_sltu   = 17'h00025;
    localparam logic [16:0] op6_nor    = 17'h00028;
    localparam logic [16:0] op6_and    = 17'h00029;
    localparam logic [16:0] op6_or     = 17'h0002a;
    localparam logic [16:0] op6_xor    = 17'h0002b;
    localparam logic [16:0] op6_sll_w  = 17'h0002e;
    localparam logic [16:0] op6_srl_w  = 17'h0002f;
    localparam logic [16:0] op6_sra_w  = 17'h00030;
    localparam logic [16:0] op6_slli_w = 17'h00081;
    localparam logic [16:0] op6_srli_w = 17'h00089;
    localparam logic [16:0] op6_srai_w = 17'h00091;

    // 2RI12 forms, compared against inst[31:22]
    localparam logic [9:0] op6_slti  = 10'h008;
    localparam logic [9:0] op6_sltui = 10'h009;
    localparam logic [9:0] op6_addi_w = 10'h00a;
    localparam logic [9:0] op6_andi  = 10'h00d;
    localparam logic [9:0] op6_ori   = 10'h00e;
    localparam logic [9:0] op6_xori  = 10'h00f;
    localparam logic [9:0] op6_ld_w  = 10'h0a2;
    localparam logic [9:0] op6_st_w  = 10'h0a6;

    // 1RI20 forms, inst[31:25]
    localparam logic [6:0] op6_lu12i_w   = 7'h0a;
    localparam logic [6:0] op6_pcaddu12i = 7'h0e;

    // branches, inst[31:26]
    localparam logic [5:0] op6_jirl = 6'h13;
    localparam logic [5:0] op6_b    = 6'h14;
    localparam logic [5:0] op6_bl   = 6'h15;
    localparam logic [5:0] op6_beq  = 6'h16;
    localparam logic [5:0] op6_bne  = 6'h17;
    localparam logic [5:0] op6_blt  = 6'h18;
    localparam logic [5:0] op6_bge  = 6'h19;
    localparam logic [5:0] op6_bltu = 6'h1a;
    localparam logic [5:0] op6_bgeu = 6'h1b;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor,
        alu_or, alu_xor, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu, br_b, br_bl, br_jirl
    } br_kind_e;

endpackage

//--- design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              flush,
    input  logic                              fs_valid,
    input  logic [31:0]                       fs_pc,
    input  logic [31:0]                       fs_inst,
    input  logic                              es_allowin,
    input  logic                              es_res_from_mem,
    input  logic                              es_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] es_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       es_rf_wdata,
    input  logic                              ms_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                              ws_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       ws_rf_wdata,
    output logic                              allowin,
    output logic                              br_taken,
    output logic [decode_pkg::xlen-1:0]       br_target,
    output logic                              es_valid,
    output logic [decode_pkg::xlen-1:0]       es_pc,
    output decode_pkg::alu_op_e               alu_op,
    output logic [decode_pkg::xlen-1:0]       alu_src1,
    output logic [decode_pkg::xlen-1:0]       alu_src2,
    output logic [decode_pkg::xlen-1:0]       store_data,
    output logic                              mem_we,
    output logic                              res_from_mem,
    output logic                              rf_we,
    output logic [decode_pkg::reg_addr_w-1:0] rf_waddr,
    output logic                              ine
);
    read_req_if rd_req ();
    dec_ctrl_if ctrl ();

    logic [decode_pkg::xlen-1:0] inst;       // held instruction
    logic [decode_pkg::xlen-1:0] rj_value;
    logic [decode_pkg::xlen-1:0] rkd_value;
    logic                        stall;

    inst_decoder u_inst_decoder (
        .inst   (inst),
        .rd_req (rd_req),
        .ctrl   (ctrl)
    );

    operand_reader u_operand_reader (
        .clk             (clk),
        .rd_req          (rd_req),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .es_rf_wdata     (es_rf_wdata),
        .es_res_from_mem (es_res_from_mem),
        .ms_rf_we        (ms_rf_we),
        .ms_rf_waddr     (ms_rf_waddr),
        .ms_rf_wdata     (ms_rf_wdata),
        .ws_rf_we        (ws_rf_we),
        .ws_rf_waddr     (ws_rf_waddr),
        .ws_rf_wdata     (ws_rf_wdata),
        .rj_value        (rj_value),
        .rkd_value       (rkd_value),
        .stall           (stall)
    );

    issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .flush        (flush),
        .fs_valid     (fs_valid),
        .fs_pc        (fs_pc),
        .fs_inst      (fs_inst),
        .es_allowin   (es_allowin),
        .ctrl         (ctrl),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .stall        (stall),
        .inst         (inst),
        .allowin      (allowin),
        .es_valid     (es_valid),
        .es_pc        (es_pc),
        .alu_op       (alu_op),
        .alu_src1     (alu_src1),
        .alu_src2     (alu_src2),
        .store_data   (store_data),
        .mem_we       (mem_we),
        .res_from_mem (res_from_mem),
        .rf_we        (rf_we),
        .rf_waddr     (rf_waddr),
        .ine          (ine),
        .br_taken     (br_taken),
        .br_target    (br_target)
    );

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic [decode_pkg::xlen-1:0] inst,
    read_req_if.src                     rd_req,
    dec_ctrl_if.src                     ctrl
);
    typedef enum logic [5:0] {
        i_add_w, i_sub_w, i_slt, i_sltu, i_nor, i_and, i_or, i_xor,
        i_sll_w, i_srl_w, i_sra_w, i_slli_w, i_srli_w, i_srai_w,
        i_addi_w, i_slti, i_sltui, i_andi, i_ori, i_xori, i_lu12i_w, i_pcaddu12i,
        i_ld_w, i_st_w, i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu, i_b, i_bl, i_jirl,
        i_none
    } inst_e;

    logic [i_none-1:0] hit;  // one bit per kept instruction
    inst_e             op;
    logic              src_is_rd;

    assign hit[i_add_w]     = inst[31:15] == decode_pkg::op6_add_w;
    assign hit[i_sub_w]     = inst[31:15] == decode_pkg::op6_sub_w;
    assign hit[i_slt]       = inst[31:15] == decode_pkg::op6_slt;
    assign hit[i_sltu]      = inst[31:15] == decode_pkg::op6_sltu;
    assign hit[i_nor]       = inst[31:15] == decode_pkg::op6_nor;
    assign hit[i_and]       = inst[31:15] == decode_pkg::op6_and;
    assign hit[i_or]        = inst[31:15] == decode_pkg::op6_or;
    assign hit[i_xor]       = inst[31:15] == decode_pkg::op6_xor;
    assign hit[i_sll_w]     = inst[31:15] == decode_pkg::op6_sll_w;
    assign hit[i_srl_w]     = inst[31:15] == decode_pkg::op6_srl_w;
    assign hit[i_sra_w]     = inst[31:15] == decode_pkg::op6_sra_w;
    assign hit[i_slli_w]    = inst[31:15] == decode_pkg::op6_slli_w;
    assign hit[i_srli_w]    = inst[31:15] == decode_pkg::op6_srli_w;
    assign hit[i_srai_w]    = inst[31:15] == decode_pkg::op6_srai_w;
    assign hit[i_addi_w]    = inst[31:22] == decode_pkg::op6_addi_w;
    assign hit[i_slti]      = inst[31:22] == decode_pkg::op6_slti;
    assign hit[i_sltui]     = inst[31:22] == decode_pkg::op6_sltui;
    assign hit[i_andi]      = inst[31:22] == decode_pkg::op6_andi;
    assign hit[i_ori]       = inst[31:22] == decode_pkg::op6_ori;
    assign hit[i_xori]      = inst[31:22] == decode_pkg::op6_xori;
    assign hit[i_lu12i_w]   = inst[31:25] == decode_pkg::op6_lu12i_w;
    assign hit[i_pcaddu12i] = inst[31:25] == decode_pkg::op6_pcaddu12i;
    assign hit[i_ld_w]      = inst[31:22] == decode_pkg::op6_ld_w;
    assign hit[i_st_w]      = inst[31:22] == decode_pkg::op6_st_w;
    assign hit[i_beq]       = inst[31:26] == decode_pkg::op6_beq;
    assign hit[i_bne]       = inst[31:26] == decode_pkg::op6_bne;
    assign hit[i_blt]       = inst[31:26] == decode_pkg::op6_blt;
    assign hit[i_bge]       = inst[31:26] == decode_pkg::op6_bge;
    assign hit[i_bltu]      = inst[31:26] == decode_pkg::op6_bltu;
    assign hit[i_bgeu]      = inst[31:26] == decode_pkg::op6_bgeu;
    assign hit[i_b]         = inst[31:26] == decode_pkg::op6_b;
    assign hit[i_bl]        = inst[31:26] == decode_pkg::op6_bl;
    assign hit[i_jirl]      = inst[31:26] == decode_pkg::op6_jirl;

    // the package encodings never overlap
    a_one_hit: assert final ($onehot0(hit));

    always_comb begin
        op = i_none;
        for (int k = 0; k < int'(i_none); k++) begin
            if (hit[k]) op = inst_e'(k);
        end
    end

    always_comb begin
        case (op)
            i_sub_w, i_beq, i_bne:           ctrl.alu_op = decode_pkg::alu_sub;
            i_slt, i_slti, i_blt, i_bge:     ctrl.alu_op = decode_pkg::alu_slt;
            i_sltu, i_sltui, i_bltu, i_bgeu: ctrl.alu_op = decode_pkg::alu_sltu;
            i_and, i_andi:                   ctrl.alu_op = decode_pkg::alu_and;
            i_nor:                           ctrl.alu_op = decode_pkg::alu_nor;
            i_or, i_ori:                     ctrl.alu_op = decode_pkg::alu_or;
            i_xor, i_xori:                   ctrl.alu_op = decode_pkg::alu_xor;
            i_sll_w, i_slli_w:               ctrl.alu_op = decode_pkg::alu_sll;
            i_srl_w, i_srli_w:               ctrl.alu_op = decode_pkg::alu_srl;
            i_sra_w, i_srai_w:               ctrl.alu_op = decode_pkg::alu_sra;
            i_lu12i_w:                       ctrl.alu_op = decode_pkg::alu_lui;
            default:                         ctrl.alu_op = decode_pkg::alu_add;
        endcase
    end

    always_comb begin
        case (op)
            i_beq:   ctrl.br_kind = decode_pkg::br_beq;
            i_bne:   ctrl.br_kind = decode_pkg::br_bne;
            i_blt:   ctrl.br_kind = decode_pkg::br_blt;
            i_bge:   ctrl.br_kind = decode_pkg::br_bge;
            i_bltu:  ctrl.br_kind = decode_pkg::br_bltu;
            i_bgeu:  ctrl.br_kind = decode_pkg::br_bgeu;
            i_b:     ctrl.br_kind = decode_pkg::br_b;
            i_bl:    ctrl.br_kind = decode_pkg::br_bl;
            i_jirl:  ctrl.br_kind = decode_pkg::br_jirl;
            default: ctrl.br_kind = decode_pkg::br_none;
        endcase
    end

    assign ctrl.src1_is_pc  = op inside {i_pcaddu12i, i_bl, i_jirl};  // pc + 4 for links
    assign ctrl.src2_is_imm = op inside {i_slli_w, i_srli_w, i_srai_w, i_addi_w, i_slti,
                                         i_sltui, i_andi, i_ori, i_xori, i_lu12i_w,
                                         i_pcaddu12i, i_ld_w, i_st_w, i_bl, i_jirl};

    assign ctrl.imm = (op inside {i_bl, i_jirl})            ? 32'd4 :
                      (op inside {i_lu12i_w, i_pcaddu12i}) ? {inst[24:5], 12'b0} :
                      (op inside {i_andi, i_ori, i_xori})   ? {20'b0, inst[21:10]} :
                                                              {{20{inst[21]}}, inst[21:10]};

    assign ctrl.br_offs = (op inside {i_b, i_bl}) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0}
                                                  : {{14{inst[25]}}, inst[25:10], 2'b0};

    assign ctrl.mem_we       = op == i_st_w;
    assign ctrl.res_from_mem = op == i_ld_w;
    assign ctrl.gr_we  = !(op inside {i_st_w, i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu,
                                      i_b, i_none});
    assign ctrl.dest   = (op == i_bl) ? decode_pkg::link_reg : inst[4:0];
    assign ctrl.ine    = op == i_none;

    assign src_is_rd      = op inside {i_st_w, i_beq, i_bne, i_blt, i_bge, i_bltu, i_bgeu};
    assign rd_req.raddr1  = inst[9:5];                          // rj
    assign rd_req.raddr2  = src_is_rd ? inst[4:0] : inst[14:10];
    // jirl still reads rj for its target
    assign rd_req.need_r1 = !(op inside {i_pcaddu12i, i_bl, i_b, i_lu12i_w, i_none});
    assign rd_req.need_r2 = src_is_rd || (!ctrl.src2_is_imm && !(op inside {i_b, i_none}));

endmodule

//--- design/issue_ctrl.sv
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              flush,
    input  logic                              fs_valid,
    input  logic [decode_pkg::xlen-1:0]       fs_pc,
    input  logic [decode_pkg::xlen-1:0]       fs_inst,
    input  logic                              es_allowin,
    dec_ctrl_if.dst                           ctrl,
    input  logic [decode_pkg::xlen-1:0]       rj_value,
    input  logic [decode_pkg::xlen-1:0]       rkd_value,
    input  logic                              stall,
    output logic [decode_pkg::xlen-1:0]       inst,
    output logic                              allowin,
    output logic                              es_valid,
    output logic [decode_pkg::xlen-1:0]       es_pc,
    output decode_pkg::alu_op_e               alu_op,
    output logic [decode_pkg::xlen-1:0]       alu_src1,
    output logic [decode_pkg::xlen-1:0]       alu_src2,
    output logic [decode_pkg::xlen-1:0]       store_data,
    output logic                              mem_we,
    output logic                              res_from_mem,
    output logic                              rf_we,
    output logic [decode_pkg::reg_addr_w-1:0] rf_waddr,
    output logic                              ine,
    output logic                              br_taken,
    output logic [decode_pkg::xlen-1:0]       br_target
);
    logic valid;
    logic rj_eq_rd;
    logic rj_lt_rd;    // unsigned
    logic rj_lt_rd_s;
    logic br_cond;

    assign allowin  = !valid || (!stall && es_allowin);
    assign es_valid = valid && !stall;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            valid <= 1'b0;
        end else if (br_taken) begin
            valid <= 1'b0;  // fetch slot behind a taken branch is dropped
        end else if (allowin) begin
            valid <= fs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_valid && allowin) begin
            es_pc <= fs_pc;
            inst  <= fs_inst;
        end
    end

    assign rj_eq_rd   = rj_value == rkd_value;
    assign rj_lt_rd   = rj_value < rkd_value;
    assign rj_lt_rd_s = $signed(rj_value) < $signed(rkd_value);

    always_comb begin
        case (ctrl.br_kind)
            decode_pkg::br_beq:  br_cond = rj_eq_rd;
            decode_pkg::br_bne:  br_cond = !rj_eq_rd;
            decode_pkg::br_blt:  br_cond = rj_lt_rd_s;
            decode_pkg::br_bge:  br_cond = !rj_lt_rd_s;
            decode_pkg::br_bltu: br_cond = rj_lt_rd;
            decode_pkg::br_bgeu: br_cond = !rj_lt_rd;
            decode_pkg::br_b, decode_pkg::br_bl, decode_pkg::br_jirl: br_cond = 1'b1;
            default:             br_cond = 1'b0;
        endcase
    end

    assign br_taken  = valid && !stall && es_allowin && br_cond;
    assign br_target = ((ctrl.br_kind == decode_pkg::br_jirl) ? rj_value : es_pc) + ctrl.br_offs;

    assign alu_op       = ctrl.alu_op;
    assign alu_src1     = ctrl.src1_is_pc ? es_pc : rj_value;
    assign alu_src2     = ctrl.src2_is_imm ? ctrl.imm : rkd_value;
    assign store_data   = rkd_value;
    assign mem_we       = ctrl.mem_we;
    assign res_from_mem = ctrl.res_from_mem;
    assign rf_we        = ctrl.gr_we && valid;
    assign rf_waddr     = ctrl.dest;
    assign ine          = ctrl.ine;

    // back-pressure keeps the held instruction in place
    a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!resetn)
        valid && !es_allowin && !flush |=> valid && $stable(es_pc));

endmodule

//--- design/operand_reader.sv
`timescale 1ns/1ps

module operand_reader (
    input  logic                              clk,
    read_req_if.dst                           rd_req,
    input  logic                              es_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] es_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       es_rf_wdata,
    input  logic                              es_res_from_mem,
    input  logic                              ms_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] ms_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       ms_rf_wdata,
    input  logic                              ws_rf_we,
    input  logic [decode_pkg::reg_addr_w-1:0] ws_rf_waddr,
    input  logic [decode_pkg::xlen-1:0]       ws_rf_wdata,
    output logic [decode_pkg::xlen-1:0]       rj_value,
    output logic [decode_pkg::xlen-1:0]       rkd_value,
    output logic                              stall
);
    logic [decode_pkg::xlen-1:0] rf_rdata1;
    logic [decode_pkg::xlen-1:0] rf_rdata2;

    // a later stage holds a newer value for ra
    function automatic logic fwd_hit(input logic                              we,
                                     input logic [decode_pkg::reg_addr_w-1:0] waddr,
                                     input logic [decode_pkg::reg_addr_w-1:0] ra);
        return we && (waddr == ra) && (ra != '0);
    endfunction

    reg_file u_reg_file (
        .clk    (clk),
        .raddr1 (rd_req.raddr1),
        .raddr2 (rd_req.raddr2),
        .we     (ws_rf_we),
        .waddr  (ws_rf_waddr),
        .wdata  (ws_rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    // youngest producer wins
    assign rj_value  = fwd_hit(es_rf_we, es_rf_waddr, rd_req.raddr1) ? es_rf_wdata :
                       fwd_hit(ms_rf_we, ms_rf_waddr, rd_req.raddr1) ? ms_rf_wdata :
                       fwd_hit(ws_rf_we, ws_rf_waddr, rd_req.raddr1) ? ws_rf_wdata : rf_rdata1;
    assign rkd_value = fwd_hit(es_rf_we, es_rf_waddr, rd_req.raddr2) ? es_rf_wdata :
                       fwd_hit(ms_rf_we, ms_rf_waddr, rd_req.raddr2) ? ms_rf_wdata :
                       fwd_hit(ws_rf_we, ws_rf_waddr, rd_req.raddr2) ? ws_rf_wdata : rf_rdata2;

    // load data not ready until memory stage
    assign stall = es_res_from_mem &&
                   (rd_req.need_r1 && fwd_hit(es_rf_we, es_rf_waddr, rd_req.raddr1) ||
                    rd_req.need_r2 && fwd_hit(es_rf_we, es_rf_waddr, rd_req.raddr2));

    // r0 reads zero whatever a later stage writes
    a_r0_rj: assert property (@(posedge clk)
        rd_req.raddr1 == '0 |-> rj_value == '0);
    a_r0_rkd: assert property (@(posedge clk)
        rd_req.raddr2 == '0 |-> rkd_value == '0);

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                              clk,
    input  logic [decode_pkg::reg_addr_w-1:0] raddr1,
    input  logic [decode_pkg::reg_addr_w-1:0] raddr2,
    input  logic                              we,
    input  logic [decode_pkg::reg_addr_w-1:0] waddr,
    input  logic [decode_pkg::xlen-1:0]       wdata,
    output logic [decode_pkg::xlen-1:0]       rdata1,
    output logic [decode_pkg::xlen-1:0]       rdata2
);
    logic [decode_pkg::xlen-1:0] regs [decode_pkg::num_regs];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];  // r0 hardwired
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- sim.f
+incdir+bench
design/decode_pkg.sv
design/decode_ifc.sv
design/reg_file.sv
design/inst_decoder.sv
design/operand_reader.sv
design/issue_ctrl.sv
design/decode_stage.sv
bench/tb_decode_stage.sv
